/* Bender.yml */
package:
  name: femtoCore

sources:
  - include_dirs:
      - include
    files:
      - src/femtoCore_pkg.sv
      - src/rvDecode.sv
      - src/rvRegFile.sv
      - src/rvExecute.sv
      - src/rvResult.sv
      - src/rvControl.sv
      - src/femtoCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/femtoCore_assert.sv
      - dv/femtoCore_tb.sv

/* dv/femtoCore_assert.sv */
`timescale 1ns/1ns

`include "femtoCore_defs.svh"

module femtoCore_assert (
   input logic        clk,
   input logic        reset,
   input logic [31:0] memAddr,
   input logic [3:0]  memWmask,
   input logic        memRstrb,
   input logic        memRbusy,
   input logic        memWbusy
);

   int   failCount = 0;  // Assertion failures so far
   logic fetched;        // First strobe seen

   always_ff @(posedge clk) begin
      if (!reset) begin
         fetched <= 1'b0;
      end else if (memRstrb) begin
         fetched <= 1'b1;
      end
   end

   // ********************
   // Reset and first fetch
   // ********************

   // Also holds after every store
   noStrobeWhileWriteBusy: assert property (@(posedge clk) disable iff (!reset)
      memWbusy |-> !memRstrb)
      else begin
         $error("read strobe while memWbusy high");
         failCount++;
      end

   firstFetchAddr: assert property (@(posedge clk) disable iff (!reset)
      (memRstrb && !fetched) |-> (memAddr == `FEMTO_RESET_ADDR))
      else begin
         $error("first fetch not at reset address");
         failCount++;
      end

   // ********************
   // Bus rules
   // ********************

   legalMask: assert property (@(posedge clk) disable iff (!reset)
      memWmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                       4'b0011, 4'b1100, 4'b1111})
      else begin
         $error("illegal write mask %b", memWmask);
         failCount++;
      end

   maskOneCycle: assert property (@(posedge clk) disable iff (!reset)
      (memWmask != 4'b0000) |=> (memWmask == 4'b0000))
      else begin
         $error("write mask held longer than one cycle");
         failCount++;
      end

   strobeOneCycle: assert property (@(posedge clk) disable iff (!reset)
      memRstrb |=> !memRstrb)
      else begin
         $error("read strobe held longer than one cycle");
         failCount++;
      end

   noStrobeWhileBusy: assert property (@(posedge clk) disable iff (!reset)
      memRbusy |-> !memRstrb)
      else begin
         $error("read strobe while previous read busy");
         failCount++;
      end

endmodule

/* dv/femtoCore_tb.sv */
`timescale 1ns/1ns

module femtoCore_tb;

   localparam int          NSIG     = 34;
   localparam int          NPROG    = 102;
   localparam logic [31:0] SIG_BASE = 32'h0000_0100;
   localparam logic [31:0] END_PC   = 32'h0000_0394;  // Final self-jump
   localparam int          LIMIT    = 20000;          // Cycles

   logic        clk = 1'b0;
   logic        reset;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;
   logic        memRstrb, memRbusy, memWbusy;

   logic [31:0] mem [0:255];  // 1 KB, word addressed
   logic [31:0] prog [0:NPROG-1];
   logic [31:0] expSig [0:NSIG-1];
   bit          written [0:NSIG-1];
   integer      seed = 32'h2396;
   int          errors = 0;
   int          sigCount = 0;
   int          rbusyLeft = 0;
   int          wbusyLeft = 12;  // Hold memWbusy after reset
   int          cycles = 0;
   bit          reachedEnd = 1'b0;
   logic        rdReq;
   logic [3:0]  wrMask;
   logic [31:0] busAddr, wrData;
   logic [31:0] rdWord = 32'd0;  // Word of the last read

   always #5 clk = ~clk;

   femtoCore femtoCore_inst (.clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
      .memRstrb, .memRbusy, .memWbusy);

   bind femtoCore femtoCore_assert assertInst (.clk(clk), .reset(reset), .memAddr(memAddr),
      .memWmask(memWmask), .memRstrb(memRstrb), .memRbusy(memRbusy), .memWbusy(memWbusy));

   // Signature word or scratch store check
   task automatic checkStore(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] data);
      int slot;
      slot = (addr - SIG_BASE) >> 2;
      if (addr >= SIG_BASE && addr < SIG_BASE + 4 * NSIG) begin
         if (mask != 4'b1111) begin
            $display("partial store into signature slot %0d at %0t", slot, $time);
            errors++;
         end else if (written[slot]) begin
            $display("signature slot %0d stored twice at %0t", slot, $time);
            errors++;
         end else if (data !== expSig[slot]) begin
            $display("mismatch at %0t: memWdata slot %0d got %h expected %h",
                     $time, slot, data, expSig[slot]);
            errors++;
         end
         written[slot] = 1'b1;
         sigCount++;
      end else if (addr < 32'h1E0 || addr > 32'h1E7) begin
         $display("store to unexpected address %h at %0t", addr, $time);
         errors++;
      end
   endtask

   // ********************
   // Memory model
   // ********************

   always begin
      @(negedge clk);               // Core outputs settled
      rdReq   = memRstrb;
      busAddr = memAddr;
      wrMask  = memWmask;
      wrData  = memWdata;
      @(posedge clk);
      #1;
      if (rdReq) begin
         rdWord    = mem[busAddr[9:2]];
         rbusyLeft = $unsigned($random(seed)) % 4;  // 0 to 3 stretch
         if (busAddr == END_PC) reachedEnd = 1'b1;
      end else if (rbusyLeft != 0) begin
         rbusyLeft--;
      end
      memRbusy = (rbusyLeft != 0);
      memRdata = memRbusy ? ~rdWord : rdWord;  // Junk until the read completes
      if (wrMask != 4'b0000) begin
         for (int b = 0; b < 4; b++) begin
            if (wrMask[b]) mem[busAddr[9:2]][8*b +: 8] = wrData[8*b +: 8];
         end
         checkStore(busAddr, wrMask, wrData);
         wbusyLeft = $unsigned($random(seed)) % 4;
      end else if (wbusyLeft != 0) begin
         wbusyLeft--;
      end
      memWbusy = (wbusyLeft != 0);
   end

   initial begin
      reset    = 1'b0;
      memRdata = 32'd0;
      memRbusy = 1'b0;
      memWbusy = 1'b1;
      // Code at 0x200, x1 = -10, x2 = 7
      prog = '{
         32'hFF600093, 32'h00700113, 32'h002081B3, 32'h10302023,  // ADD
         32'h402081B3, 32'h10302223, 32'h0020A1B3, 32'h10302423,  // SUB SLT
         32'h0020B1B3, 32'h10302623, 32'h0020C1B3, 32'h10302823,  // SLTU XOR
         32'h0020E1B3, 32'h10302A23, 32'h0020F1B3, 32'h10302C23,  // OR AND
         32'hFF70A193, 32'h10302E23, 32'hFFF13193, 32'h12302023,  // SLTI SLTIU
         32'h0FF0C193, 32'h12302223, 32'h10016193, 32'h12302423,  // XORI ORI
         32'h7F00F193, 32'h12302623, 32'h123451B7, 32'h12302823,  // ANDI LUI
         32'h00001197, 32'h12302A23, 32'h000091B3, 32'h12302C23,  // AUIPC SLL 0
         32'h00109193, 32'h12302E23, 32'h01F11193, 32'h14302023,  // SLLI 1, 31
         32'h0000D1B3, 32'h14302223, 32'h0010D193, 32'h14302423,  // SRL 0, 1
         32'h01F0D193, 32'h14302623, 32'h4000D1B3, 32'h14302823,  // SRL 31, SRA 0
         32'h4010D193, 32'h14302A23, 32'h41F0D193, 32'h14302C23,  // SRA 1, 31
         32'h1F000183, 32'h14302E23, 32'h1F304183, 32'h16302023,  // LB LBU
         32'h1F001183, 32'h16302223, 32'h1F205183, 32'h16302423,  // LH LHU
         32'h1F002183, 32'h16302623, 32'h1E100023, 32'h1E2000A3,  // LW, SB lanes
         32'h1E100123, 32'h1E2001A3, 32'h1E002183, 32'h16302823,
         32'h1E101223, 32'h1E201323, 32'h1E402183, 32'h16302A23,  // SH lanes
         32'h00000213, 32'h00000313, 32'h00210463, 32'h00126213,  // BEQ taken
         32'h00208463, 32'h00136313, 32'h00209463, 32'h00226213,  // BNE
         32'h00211463, 32'h00236313, 32'h0020C463, 32'h00426213,  // BLT
         32'h00114463, 32'h00436313, 32'h00115463, 32'h00826213,  // BGE
         32'h0020D463, 32'h00836313, 32'h00116463, 32'h01026213,  // BLTU
         32'h0020E463, 32'h01036313, 32'h0020F463, 32'h02026213,  // BGEU
         32'h00117463, 32'h02036313, 32'h16402C23, 32'h16602E23,
         32'h18502023, 32'h00000417, 32'h00C403E7, 32'h18202223,  // JALR skips SW
         32'h18702223, 32'h0000006F};
      expSig = '{
         32'hFFFFFFFD, 32'hFFFFFFEF, 32'h00000001, 32'h00000000,
         32'hFFFFFFF1, 32'hFFFFFFF7, 32'h00000006, 32'h00000001,
         32'h00000001, 32'hFFFFFF09, 32'h00000107, 32'h000007F0,
         32'h12345000, 32'h00001270, 32'hFFFFFFF6, 32'hFFFFFFEC,
         32'h80000000, 32'hFFFFFFF6, 32'h7FFFFFFB, 32'h00000001,
         32'hFFFFFFF6, 32'hFFFFFFFB, 32'hFFFFFFFF, 32'hFFFFFF85,  // Shifts, LB
         32'h0000009A, 32'hFFFFF085, 32'h00009A7F, 32'h9A7FF085,  // LBU LH LHU LW
         32'h07F607F6, 32'h0007FFF6, 32'h00000000, 32'h0000003F,  // Lanes, branches
         32'h00000004, 32'h0000038C};                             // JAL, JALR links
      for (int i = 0; i < 256; i++) begin
         mem[i] = {16'hA5C3, i[15:0]} ^ (i << 18);  // Address dependent fill
      end
      for (int i = 0; i < NPROG; i++) begin
         mem[128 + i] = prog[i];
      end
      mem[0]   = 32'h200002EF;  // JAL x5 to 0x200
      mem[1]   = 32'h10202023;  // Never reached
      mem[124] = 32'h9A7FF085;  // Load data at 0x1F0
      repeat (8) @(posedge clk);
      #1 reset = 1'b1;

      // Run until the self-jump is fetched
      while (!reachedEnd && cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (!reachedEnd) begin
         $display("timeout waiting for the program to reach its final self-jump");
         errors++;
      end
      if (sigCount != NSIG) begin
         $display("only %0d of %0d signature words were stored", sigCount, NSIG);
         errors++;
      end
      $display("%0d signature words, %0d errors, %0d assertion failures", sigCount,
               errors, femtoCore_inst.assertInst.failCount);
      if (errors == 0 && femtoCore_inst.assertInst.failCount == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* femtoCore.f */
+incdir+include
src/femtoCore_pkg.sv
src/rvDecode.sv
src/rvRegFile.sv
src/rvExecute.sv
src/rvResult.sv
src/rvControl.sv
src/femtoCore.sv
dv/femtoCore_assert.sv
dv/femtoCore_tb.sv

/* include/femtoCore_defs.svh */
`ifndef FEMTO_CORE_DEFS_SVH
`define FEMTO_CORE_DEFS_SVH

// ********************
// Core-wide constants
// ********************

// First fetch address after reset
`define FEMTO_RESET_ADDR 32'h0000_0000

// Data and address width
`define FEMTO_XLEN 32

// Integer register count, x0 included
`define FEMTO_NREGS 32

`endif

/* src/femtoCore.sv */
`timescale 1ns/1ns

module femtoCore import femtoCore_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,
   input  logic [31:0] memRdata,
   output logic        memRstrb,
   input  logic        memRbusy,
   input  logic        memWbusy
);

   opcode_e     opcode;
   aluFunc_e    func3;
   logic        funcQual, useRs2;
   logic [4:0]  rs1, rs2, rd;
   logic [31:0] imm, rs1Data, rs2Data, wbData;
   logic [31:0] aluOut, addSum, pc;
   logic        aluBusy, takeCond, aluStart, instrLoad, writeBack;
   logic [3:0]  storeMask;

   // ********************
   // Datapath
   // ********************

   rvDecode decodeInst (.clk, .reset, .instrLoad, .memRdata, .opcode, .func3,
      .funcQual, .rs1, .rs2, .rd, .imm, .useRs2);

   rvRegFile regFileInst (.clk, .rs1, .rs2, .rd, .writeBack, .wbData,
      .rs1Data, .rs2Data);

   rvExecute executeInst (.clk, .reset, .aluStart, .func3, .funcQual, .useRs2,
      .rs1Data, .rs2Data, .imm, .aluOut, .addSum, .aluBusy, .takeCond);

   rvResult resultInst (.opcode, .func3, .memRdata, .memAddr, .aluOut, .imm, .pc,
      .rs2Data, .addSum, .wbData, .memWdata, .storeMask);

   // Sequencing and memory strobes
   rvControl controlInst (.clk, .reset, .opcode, .imm, .addSum, .takeCond,
      .aluBusy, .storeMask, .memRbusy, .memWbusy, .memAddr, .pc, .memRstrb,
      .memWmask, .instrLoad, .aluStart, .writeBack);

endmodule

/* src/femtoCore_pkg.sv */
package femtoCore_pkg;

   // ********************
   // Major opcodes
   // ********************

   typedef enum logic [4:0] {
      opLoad    = 5'b00000,
      opOpImm   = 5'b00100,
      opAuipc   = 5'b00101,
      opStore   = 5'b01000,
      opOp      = 5'b01100,
      opLui     = 5'b01101,
      opBranch  = 5'b11000,
      opJalr    = 5'b11001,
      opJal     = 5'b11011,
      opIllegal = 5'b11111  // Anything not in RV32I subset
   } opcode_e;

   // func3 seen as ALU operation
   typedef enum logic [2:0] {
      fAddSub = 3'b000,
      fSll    = 3'b001,
      fSlt    = 3'b010,
      fSltu   = 3'b011,
      fXor    = 3'b100,
      fSrx    = 3'b101,  // SRL or SRA
      fOr     = 3'b110,
      fAnd    = 3'b111
   } aluFunc_e;

   // ********************
   // Sequencer states, one-hot
   // ********************

   typedef enum logic [7:0] {
      stFetch       = 8'b0000_0001,
      stWaitInstr   = 8'b0000_0010,
      stFetchRegs   = 8'b0000_0100,
      stExecute     = 8'b0000_1000,
      stLoad        = 8'b0001_0000,
      stWaitAluData = 8'b0010_0000,
      stStore       = 8'b0100_0000,
      stWaitStore   = 8'b1000_0000
   } ctrlState_e;

endpackage

/* src/rvControl.sv */
`timescale 1ns/1ns

`include "femtoCore_defs.svh"

module rvControl import femtoCore_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  opcode_e     opcode,
   input  logic [31:0] imm,
   input  logic [31:0] addSum,
   input  logic        takeCond,
   input  logic        aluBusy,
   input  logic [3:0]  storeMask,
   input  logic        memRbusy,
   input  logic        memWbusy,
   output logic [31:0] memAddr,
   output logic [31:0] pc,
   output logic        memRstrb,
   output logic [3:0]  memWmask,
   output logic        instrLoad,
   output logic        aluStart,
   output logic        writeBack
);

   ctrlState_e  state;
   logic        isAlu;
   logic        isLdSt;
   logic        takeBranch;
   logic [31:0] nextPc;

   assign isAlu      = (opcode == opOp) | (opcode == opOpImm);
   assign isLdSt     = (opcode == opLoad) | (opcode == opStore);
   assign takeBranch = (opcode == opJal) | ((opcode == opBranch) & takeCond);

   // JALR clears bit 0 of its target
   assign nextPc = (opcode == opJalr) ? {addSum[31:1], 1'b0} :
                   takeBranch         ? pc + imm : pc + 32'd4;

   // ********************
   // State decoded strobes
   // ********************

   assign memRstrb  = (state == stFetch) | (state == stLoad);
   assign memWmask  = (state == stStore) ? storeMask : 4'b0000;  // One cycle only
   assign instrLoad = (state == stWaitInstr) & !memRbusy;
   assign aluStart  = (state == stExecute) & isAlu;
   assign writeBack = ((state == stExecute) & (opcode != opBranch) & (opcode != opStore)) |
                      (state == stWaitAluData);

   // ********************
   // Sequencer
   // ********************

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= stWaitStore;               // Wait for memory to settle
         pc    <= `FEMTO_RESET_ADDR;
      end else begin
         unique case (state)
            stFetch:     state <= stWaitInstr;
            stWaitInstr: if (!memRbusy) state <= stFetchRegs;
            stFetchRegs: state <= stExecute;  // Register read latency
            stExecute: begin
               pc      <= nextPc;
               memAddr <= isLdSt ? addSum : nextPc;
               if (opcode == opLoad) begin
                  state <= stLoad;
               end else if (opcode == opStore) begin
                  state <= stStore;
               end else if (isAlu) begin
                  state <= stWaitAluData;
               end else begin
                  state <= stFetch;           // Jumps, branches, LUI, AUIPC
               end
            end
            stLoad:  state <= stWaitAluData;
            stStore: state <= stWaitStore;
            stWaitAluData, stWaitStore: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  memAddr <= pc;              // Point at next instruction
                  state   <= stFetch;
               end
            end
            default: state <= stWaitStore;    // Recover from bad encoding
         endcase
      end
   end

endmodule

/* src/rvDecode.sv */
`timescale 1ns/1ns

module rvDecode import femtoCore_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        instrLoad,  // Latch fetched word
   input  logic [31:0] memRdata,
   output opcode_e     opcode,
   output aluFunc_e    func3,
   output logic        funcQual,   // SUB or SRA
   output logic [4:0]  rs1,
   output logic [4:0]  rs2,
   output logic [4:0]  rd,
   output logic [31:0] imm,
   output logic        useRs2      // Operand 2 from register file
);

   logic [31:0] instr;
   logic        isShift;

   // Instruction register
   always_ff @(posedge clk) begin
      if (!reset) begin
         instr <= 32'h0000_0013;  // ADDI x0, x0, 0
      end else if (instrLoad) begin
         instr <= memRdata;
      end
   end

   // ********************
   // Fields
   // ********************

   assign rd    = instr[11:7];
   assign rs1   = instr[19:15];
   assign rs2   = instr[24:20];
   assign func3 = aluFunc_e'(instr[14:12]);

   assign isShift  = (instr[13:12] == 2'b01);        // func3 001 or 101
   assign funcQual = (isShift | instr[5]) & instr[30]; // SUB only in reg form

   // Map unsupported major opcodes to opIllegal
   always_comb begin
      case (instr[6:2])
         opLoad, opOpImm, opAuipc, opStore, opOp,
         opLui, opBranch, opJalr, opJal: opcode = opcode_e'(instr[6:2]);
         default:                        opcode = opIllegal;
      endcase
   end

   assign useRs2 = (opcode == opOp) | (opcode == opBranch);

   // ********************
   // Immediate formats
   // ********************

   always_comb begin
      case (opcode)
         opLui, opAuipc: imm = {instr[31:12], 12'b0};                          // U
         opStore:        imm = {{21{instr[31]}}, instr[30:25], instr[11:7]}; // S
         opBranch: begin                                                      // B
            imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         end
         opJal: begin                                                         // J
            imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
         end
         default:        imm = {{21{instr[31]}}, instr[30:20]};               // I
      endcase
   end

endmodule

/* src/rvExecute.sv */
`timescale 1ns/1ns

module rvExecute import femtoCore_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        aluStart,  // Capture operands and result
   input  aluFunc_e    func3,
   input  logic        funcQual,
   input  logic        useRs2,
   input  logic [31:0] rs1Data,
   input  logic [31:0] rs2Data,
   input  logic [31:0] imm,
   output logic [31:0] aluOut,
   output logic [31:0] addSum,    // rs1 + op2, also used for addresses
   output logic        aluBusy,   // Serial shift in progress
   output logic        takeCond   // Branch predicate
);

   logic [31:0] op2;
   logic [32:0] diff;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic [31:0] aluReg;
   logic [4:0]  shamt;            // Bits left to shift

   assign op2    = useRs2 ? rs2Data : imm;
   assign addSum = rs1Data + op2;

   // ********************
   // Comparator
   // ********************

   // One 33-bit subtract gives SUB, EQ, LT and LTU
   assign diff = {1'b1, ~op2} + {1'b0, rs1Data} + 33'd1;
   assign ltu  = diff[32];                                      // Borrow out
   assign lt   = (rs1Data[31] ^ op2[31]) ? rs1Data[31] : diff[32]; // Signs differ
   assign eq   = (diff[31:0] == 32'd0);

   // Branch func3 reuses the ALU encoding
   always_comb begin
      case (func3)
         fAddSub: takeCond = eq;    // BEQ
         fSll:    takeCond = !eq;   // BNE
         fXor:    takeCond = lt;    // BLT
         fSrx:    takeCond = !lt;   // BGE
         fOr:     takeCond = ltu;   // BLTU
         fAnd:    takeCond = !ltu;  // BGEU
         default: takeCond = 1'b0;
      endcase
   end

   // ********************
   // Result register and shifter
   // ********************

   assign aluBusy = (shamt != 5'd0);
   assign aluOut  = aluReg;

   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= 5'd0;
      end else if (aluStart) begin
         shamt <= ((func3 == fSll) || (func3 == fSrx)) ? op2[4:0] : 5'd0;
      end else if (aluBusy) begin
         shamt <= shamt - 5'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (aluStart) begin
         case (func3)
            fAddSub: aluReg <= funcQual ? diff[31:0] : addSum;
            fSlt:    aluReg <= {31'b0, lt};
            fSltu:   aluReg <= {31'b0, ltu};
            fXor:    aluReg <= rs1Data ^ op2;
            fOr:     aluReg <= rs1Data | op2;
            fAnd:    aluReg <= rs1Data & op2;
            default: aluReg <= rs1Data;  // Shift source
         endcase
      end else if (aluBusy) begin
         if (func3 == fSll) begin
            aluReg <= {aluReg[30:0], 1'b0};
         end else begin
            aluReg <= {funcQual & aluReg[31], aluReg[31:1]};  // SRA keeps sign
         end
      end
   end

endmodule

/* src/rvRegFile.sv */
`timescale 1ns/1ns

`include "femtoCore_defs.svh"

module rvRegFile (
   input  logic        clk,
   input  logic [4:0]  rs1,
   input  logic [4:0]  rs2,
   input  logic [4:0]  rd,
   input  logic        writeBack,
   input  logic [31:0] wbData,
   output logic [31:0] rs1Data,  // Valid one cycle after rs1
   output logic [31:0] rs2Data
);

   logic [`FEMTO_XLEN-1:0] regs [`FEMTO_NREGS];

   // Two registered reads every cycle
   // x0 forced to zero on read, never stored
   always_ff @(posedge clk) begin
      rs1Data <= (rs1 == 5'd0) ? '0 : regs[rs1];
      rs2Data <= (rs2 == 5'd0) ? '0 : regs[rs2];
   end

   // Single write port
   always_ff @(posedge clk) begin
      if (writeBack && (rd != 5'd0)) begin
         regs[rd] <= wbData;
      end
   end

endmodule

/* src/rvResult.sv */
`timescale 1ns/1ns

module rvResult import femtoCore_pkg::*; (
   input  opcode_e     opcode,
   input  aluFunc_e    func3,
   input  logic [31:0] memRdata,
   input  logic [31:0] memAddr,    // Holds load address during load wait
   input  logic [31:0] aluOut,
   input  logic [31:0] imm,
   input  logic [31:0] pc,
   input  logic [31:0] rs2Data,
   input  logic [31:0] addSum,     // Store address
   output logic [31:0] wbData,
   output logic [31:0] memWdata,
   output logic [3:0]  storeMask
);

   logic [2:0]  f3;
   logic        byteAcc;
   logic        halfAcc;
   logic        sign;
   logic [15:0] half;
   logic [7:0]  lsByte;
   logic [31:0] loadData;

   assign f3      = func3;
   assign byteAcc = (f3[1:0] == 2'b00);
   assign halfAcc = (f3[1:0] == 2'b01);

   // ********************
   // Load alignment
   // ********************

   assign half     = memAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign lsByte   = memAddr[0] ? half[15:8] : half[7:0];
   assign sign     = !f3[2] & (byteAcc ? lsByte[7] : half[15]); // LBU, LHU zero fill
   assign loadData = byteAcc ? {{24{sign}}, lsByte} :
                     halfAcc ? {{16{sign}}, half} : memRdata;

   // ********************
   // Store lanes and mask
   // ********************

   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = addSum[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = addSum[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = addSum[0] ? rs2Data[7:0] :
                            addSum[1] ? rs2Data[15:8] : rs2Data[31:24];

   assign storeMask = byteAcc ? (4'b0001 << addSum[1:0]) :
                      halfAcc ? (addSum[1] ? 4'b1100 : 4'b0011) : 4'b1111;

   // Write-back select
   always_comb begin
      case (opcode)
         opLui:         wbData = imm;
         opOp, opOpImm: wbData = aluOut;
         opAuipc:       wbData = pc + imm;
         opJal, opJalr: wbData = pc + 32'd4;   // Link address
         opLoad:        wbData = loadData;
         default:       wbData = 32'd0;
      endcase
   end

endmodule
